// File: design/cpuPkg.sv
package cpuPkg;

   // Basic datapath widths
   typedef logic [31:0] word_t;
   typedef logic [4:0]  regIdx_t;
   typedef logic [3:0]  byteEn_t;

   // Primary opcodes of the supported subset
   typedef enum logic [5:0] {
      OP_RTYPE = 6'h00, OP_J    = 6'h02, OP_JAL  = 6'h03, OP_BEQ  = 6'h04,
      OP_BNE   = 6'h05, OP_ADDIU = 6'h09, OP_SLTI = 6'h0a, OP_ANDI = 6'h0c,
      OP_ORI   = 6'h0d, OP_XORI = 6'h0e, OP_LUI  = 6'h0f, OP_LB   = 6'h20,
      OP_LH    = 6'h21, OP_LW   = 6'h23, OP_LBU  = 6'h24, OP_LHU  = 6'h25,
      OP_SB    = 6'h28, OP_SH   = 6'h29, OP_SW   = 6'h2b
   } opcode_t;

   // Function field of R-type instructions
   typedef enum logic [5:0] {
      FN_SLL  = 6'h00, FN_JR  = 6'h08, FN_JALR = 6'h09, FN_ADDU = 6'h21,
      FN_SUBU = 6'h23, FN_AND = 6'h24, FN_OR   = 6'h25, FN_XOR  = 6'h26,
      FN_SLT  = 6'h2a
   } funct_t;

   typedef enum logic [3:0] {
      ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT, ALU_SLL, ALU_LUI
   } aluOp_t;

   typedef enum logic [1:0] {
      MEM_BYTE = 2'd0, MEM_HALF = 2'd1, MEM_WORD = 2'd2
   } memSize_t;

   // All-zero bundle is a no-op
   typedef struct packed {
      logic     regWrite;
      logic     memToReg;
      logic     memRead;
      logic     memWrite;
      memSize_t memSize;
      logic     loadSigned;
      logic     aluSrcImm;
      logic     shift;
      logic     regDst;
      logic     branchEq;
      logic     branchNe;
      logic     jump;
      logic     jumpReg;
      logic     link;
      aluOp_t   aluOp;
   } ctrl_t;

   // F to E payload
   typedef struct packed {
      ctrl_t       ctrl;
      word_t       opA;
      word_t       opB;
      word_t       imm;
      logic [4:0]  shamt;
      regIdx_t     rs;
      regIdx_t     rt;
      regIdx_t     rd;
      logic [25:0] target;
      word_t       pc;
   } feStage_t;

   // E to M payload
   typedef struct packed {
      logic     regWrite;
      logic     memToReg;
      memSize_t memSize;
      logic     loadSigned;
      logic     link;
      regIdx_t  dest;
      word_t    aluResult;
      word_t    pc;
   } emStage_t;

   localparam word_t   resetVector = 32'h4000_0000;
   // Return address skips the delay slot
   localparam word_t   linkOffset  = 32'd8;
   localparam regIdx_t linkReg     = 5'd31;

endpackage

// File: design/cpuTop.sv
`timescale 1ns/100ps

module cpuTop (
   input  logic            clk,
   input  logic            reset,
   input  logic            stall,
   input  cpuPkg::word_t   instrWord,
   input  cpuPkg::word_t   dataRdata,
   output cpuPkg::word_t   pc,
   output cpuPkg::word_t   dataAddr,
   output cpuPkg::word_t   dataWdata,
   output cpuPkg::byteEn_t dataWe
);

   // Branch redirect from E
   logic             takeBranch;
   cpuPkg::word_t    branchTarget;

   // Register file read side
   cpuPkg::regIdx_t  raddrA;
   cpuPkg::regIdx_t  raddrB;
   cpuPkg::word_t    regA;
   cpuPkg::word_t    regB;

   // Write-back bus
   logic             wbWrite;
   cpuPkg::regIdx_t  wbAddr;
   cpuPkg::word_t    wbData;

   // Stage payloads
   cpuPkg::feStage_t feD;
   cpuPkg::feStage_t feQ;
   cpuPkg::emStage_t emD;
   cpuPkg::emStage_t emQ;

   memReqIf memReq ();

   pcCounter pcCounter_i (
      .clk          (clk),
      .reset        (reset),
      .stall        (stall),
      .takeBranch   (takeBranch),
      .branchTarget (branchTarget),
      .pc           (pc)
   );

   regFile regFile_i (
      .clk     (clk),
      .raddrA  (raddrA),
      .raddrB  (raddrB),
      .rdataA  (regA),
      .rdataB  (regB),
      .writeEn (wbWrite),
      .waddr   (wbAddr),
      .wdata   (wbData)
   );

   // F stage
   decodeUnit decodeUnit_i (
      .instrWord (instrWord),
      .pc        (pc),
      .regA      (regA),
      .regB      (regB),
      .wbWrite   (wbWrite),
      .wbAddr    (wbAddr),
      .wbData    (wbData),
      .raddrA    (raddrA),
      .raddrB    (raddrB),
      .feOut     (feD)
   );

   stageReg #(.payload_t(cpuPkg::feStage_t)) feReg_i (
      .clk   (clk),
      .reset (reset),
      .stall (stall),
      .d     (feD),
      .q     (feQ)
   );

   // E stage, forwarding from the M payload
   executeUnit executeUnit_i (
      .stall        (stall),
      .fe           (feQ),
      .mResult      (emQ.aluResult),
      .mDest        (emQ.dest),
      .mRegWrite    (emQ.regWrite),
      .em           (emD),
      .takeBranch   (takeBranch),
      .branchTarget (branchTarget),
      .mem          (memReq.exec)
   );

   stageReg #(.payload_t(cpuPkg::emStage_t)) emReg_i (
      .clk   (clk),
      .reset (reset),
      .stall (stall),
      .d     (emD),
      .q     (emQ)
   );

   // M stage
   memWriteback memWriteback_i (
      .clk       (clk),
      .em        (emQ),
      .dataRdata (dataRdata),
      .mem       (memReq.wb),
      .regWrite  (wbWrite),
      .writeAddr (wbAddr),
      .writeData (wbData)
   );

   // Data memory port
   assign dataAddr  = memReq.addr;
   assign dataWdata = memReq.storeData;
   assign dataWe    = memReq.byteEn;

endmodule

// File: design/decodeUnit.sv
`timescale 1ns/100ps

module decodeUnit (
   input  cpuPkg::word_t    instrWord,
   input  cpuPkg::word_t    pc,
   input  cpuPkg::word_t    regA,
   input  cpuPkg::word_t    regB,
   input  logic             wbWrite,
   input  cpuPkg::regIdx_t  wbAddr,
   input  cpuPkg::word_t    wbData,
   output cpuPkg::regIdx_t  raddrA,
   output cpuPkg::regIdx_t  raddrB,
   output cpuPkg::feStage_t feOut
);

   cpuPkg::opcode_t op;
   cpuPkg::funct_t  fn;
   cpuPkg::regIdx_t rs;
   cpuPkg::regIdx_t rt;
   cpuPkg::regIdx_t rd;
   logic [15:0]     imm16;
   logic            zeroExt;
   cpuPkg::ctrl_t   ctrl;

   // Instruction fields
   assign op     = cpuPkg::opcode_t'(instrWord[31:26]);
   assign fn     = cpuPkg::funct_t'(instrWord[5:0]);
   assign rs     = instrWord[25:21];
   assign rt     = instrWord[20:16];
   assign rd     = instrWord[15:11];
   assign imm16  = instrWord[15:0];
   assign raddrA = rs;
   assign raddrB = rt;

   // Logical immediates and LUI are zero extended
   assign zeroExt = (op == cpuPkg::OP_ANDI) || (op == cpuPkg::OP_ORI) ||
                    (op == cpuPkg::OP_XORI) || (op == cpuPkg::OP_LUI);

   always_comb begin
      ctrl = '0;
      case (op)
         cpuPkg::OP_RTYPE: begin
            ctrl.regWrite = 1'b1;
            ctrl.regDst   = 1'b1;
            case (fn)
               cpuPkg::FN_ADDU: ctrl.aluOp = cpuPkg::ALU_ADD;
               cpuPkg::FN_SUBU: ctrl.aluOp = cpuPkg::ALU_SUB;
               cpuPkg::FN_AND:  ctrl.aluOp = cpuPkg::ALU_AND;
               cpuPkg::FN_OR:   ctrl.aluOp = cpuPkg::ALU_OR;
               cpuPkg::FN_XOR:  ctrl.aluOp = cpuPkg::ALU_XOR;
               cpuPkg::FN_SLT:  ctrl.aluOp = cpuPkg::ALU_SLT;
               cpuPkg::FN_SLL: begin
                  ctrl.aluOp = cpuPkg::ALU_SLL;
                  ctrl.shift = 1'b1;
               end
               cpuPkg::FN_JR: begin
                  ctrl.regWrite = 1'b0;
                  ctrl.jumpReg  = 1'b1;
               end
               cpuPkg::FN_JALR: begin
                  // No link write when rd is r0
                  ctrl.regWrite = (rd != '0);
                  ctrl.jumpReg  = 1'b1;
                  ctrl.link     = 1'b1;
               end
               // Unknown funct becomes a no-op
               default: ctrl.regWrite = 1'b0;
            endcase
         end
         cpuPkg::OP_ADDIU, cpuPkg::OP_SLTI, cpuPkg::OP_ANDI,
         cpuPkg::OP_ORI, cpuPkg::OP_XORI, cpuPkg::OP_LUI: begin
            ctrl.regWrite  = 1'b1;
            ctrl.aluSrcImm = 1'b1;
            case (op)
               cpuPkg::OP_SLTI: ctrl.aluOp = cpuPkg::ALU_SLT;
               cpuPkg::OP_ANDI: ctrl.aluOp = cpuPkg::ALU_AND;
               cpuPkg::OP_ORI:  ctrl.aluOp = cpuPkg::ALU_OR;
               cpuPkg::OP_XORI: ctrl.aluOp = cpuPkg::ALU_XOR;
               cpuPkg::OP_LUI:  ctrl.aluOp = cpuPkg::ALU_LUI;
               default:         ctrl.aluOp = cpuPkg::ALU_ADD;
            endcase
         end
         cpuPkg::OP_LB, cpuPkg::OP_LBU, cpuPkg::OP_LH, cpuPkg::OP_LHU,
         cpuPkg::OP_LW: begin
            ctrl.regWrite   = 1'b1;
            ctrl.memToReg   = 1'b1;
            ctrl.memRead    = 1'b1;
            ctrl.aluSrcImm  = 1'b1;
            ctrl.loadSigned = (op == cpuPkg::OP_LB) || (op == cpuPkg::OP_LH);
            if ((op == cpuPkg::OP_LB) || (op == cpuPkg::OP_LBU)) begin
               ctrl.memSize = cpuPkg::MEM_BYTE;
            end else if ((op == cpuPkg::OP_LH) || (op == cpuPkg::OP_LHU)) begin
               ctrl.memSize = cpuPkg::MEM_HALF;
            end else begin
               ctrl.memSize = cpuPkg::MEM_WORD;
            end
         end
         cpuPkg::OP_SB, cpuPkg::OP_SH, cpuPkg::OP_SW: begin
            ctrl.memWrite  = 1'b1;
            ctrl.aluSrcImm = 1'b1;
            if (op == cpuPkg::OP_SB) begin
               ctrl.memSize = cpuPkg::MEM_BYTE;
            end else if (op == cpuPkg::OP_SH) begin
               ctrl.memSize = cpuPkg::MEM_HALF;
            end else begin
               ctrl.memSize = cpuPkg::MEM_WORD;
            end
         end
         cpuPkg::OP_BEQ: ctrl.branchEq = 1'b1;
         cpuPkg::OP_BNE: ctrl.branchNe = 1'b1;
         cpuPkg::OP_J:   ctrl.jump     = 1'b1;
         cpuPkg::OP_JAL: begin
            ctrl.jump     = 1'b1;
            ctrl.link     = 1'b1;
            ctrl.regWrite = 1'b1;
         end
         default: ctrl = '0;
      endcase
   end

   // Payload towards E
   always_comb begin
      feOut.ctrl = ctrl;
      // Write-back bypass covers the distance-two hazard
      feOut.opA = (wbWrite && (wbAddr == rs) && (rs != '0)) ? wbData : regA;
      feOut.opB = (wbWrite && (wbAddr == rt) && (rt != '0)) ? wbData : regB;
      feOut.imm = zeroExt ? {16'h0000, imm16} : {{16{imm16[15]}}, imm16};
      feOut.shamt  = instrWord[10:6];
      feOut.rs     = rs;
      feOut.rt     = rt;
      feOut.rd     = rd;
      feOut.target = instrWord[25:0];
      feOut.pc     = pc;
   end

endmodule

// File: design/executeUnit.sv
`timescale 1ns/100ps

module executeUnit (
   input  logic             stall,
   input  cpuPkg::feStage_t fe,
   input  cpuPkg::word_t    mResult,
   input  cpuPkg::regIdx_t  mDest,
   input  logic             mRegWrite,
   output cpuPkg::emStage_t em,
   output logic             takeBranch,
   output cpuPkg::word_t    branchTarget,
   memReqIf.exec            mem
);

   cpuPkg::word_t fwdA;
   cpuPkg::word_t fwdB;
   cpuPkg::word_t aluA;
   cpuPkg::word_t aluB;
   cpuPkg::word_t aluOut;
   cpuPkg::word_t pcPlus4;
   logic          opEqual;

   // M to E forwarding of the ALU result
   assign fwdA = (mRegWrite && (mDest != '0) && (mDest == fe.rs)) ? mResult : fe.opA;
   assign fwdB = (mRegWrite && (mDest != '0) && (mDest == fe.rt)) ? mResult : fe.opB;

   // Shift amount rides on A, immediate on B
   assign aluA = fe.ctrl.shift ? {27'd0, fe.shamt} : fwdA;
   assign aluB = fe.ctrl.aluSrcImm ? fe.imm : fwdB;

   always_comb begin
      case (fe.ctrl.aluOp)
         cpuPkg::ALU_ADD: aluOut = aluA + aluB;
         cpuPkg::ALU_SUB: aluOut = aluA - aluB;
         cpuPkg::ALU_AND: aluOut = aluA & aluB;
         cpuPkg::ALU_OR:  aluOut = aluA | aluB;
         cpuPkg::ALU_XOR: aluOut = aluA ^ aluB;
         cpuPkg::ALU_SLT: aluOut = {31'd0, $signed(aluA) < $signed(aluB)};
         cpuPkg::ALU_SLL: aluOut = aluB << aluA[4:0];
         cpuPkg::ALU_LUI: aluOut = {aluB[15:0], 16'h0000};
         default:         aluOut = '0;
      endcase
   end

   // Branch resolution, targets relative to the delay slot
   assign opEqual    = (fwdA == fwdB);
   assign pcPlus4    = fe.pc + 32'd4;
   assign takeBranch = (fe.ctrl.branchEq && opEqual) || (fe.ctrl.branchNe && !opEqual) ||
                       fe.ctrl.jump || fe.ctrl.jumpReg;

   always_comb begin
      if (fe.ctrl.jumpReg) begin
         branchTarget = fwdA;
      end else if (fe.ctrl.jump) begin
         branchTarget = {pcPlus4[31:28], fe.target, 2'b00};
      end else begin
         branchTarget = pcPlus4 + {fe.imm[29:0], 2'b00};
      end
   end

   // Store lanes, little-endian byte order
   always_comb begin
      mem.addr    = aluOut;
      mem.memSize = fe.ctrl.memSize;
      mem.isLoad  = fe.ctrl.memRead && !stall;
      case (fe.ctrl.memSize)
         cpuPkg::MEM_BYTE: begin
            mem.storeData = {4{fwdB[7:0]}};
            mem.byteEn    = 4'b0001 << aluOut[1:0];
         end
         cpuPkg::MEM_HALF: begin
            mem.storeData = {2{fwdB[15:0]}};
            mem.byteEn    = aluOut[1] ? 4'b1100 : 4'b0011;
         end
         default: begin
            mem.storeData = fwdB;
            mem.byteEn    = 4'b1111;
         end
      endcase
      // Issue only in the unstalled cycle
      if (!fe.ctrl.memWrite || stall) begin
         mem.byteEn = '0;
      end
   end

   // JAL has no encoded destination, M picks the link register
   always_comb begin
      em.regWrite   = fe.ctrl.regWrite;
      em.memToReg   = fe.ctrl.memToReg;
      em.memSize    = fe.ctrl.memSize;
      em.loadSigned = fe.ctrl.loadSigned;
      em.link       = fe.ctrl.link;
      if (fe.ctrl.link && !fe.ctrl.jumpReg) begin
         em.dest = '0;
      end else begin
         em.dest = fe.ctrl.regDst ? fe.rd : fe.rt;
      end
      em.aluResult = aluOut;
      em.pc        = fe.pc;
   end

endmodule

// File: design/memReqIf.sv
`timescale 1ns/100ps

// One data-memory request per cycle, issued from E
interface memReqIf;
   cpuPkg::word_t    addr;
   cpuPkg::word_t    storeData;
   cpuPkg::byteEn_t  byteEn;
   logic             isLoad;
   cpuPkg::memSize_t memSize;

   // Execute side drives the request
   modport exec(output addr, storeData, byteEn, isLoad, memSize);

   // Write-back side only needs load info
   modport wb(input addr, isLoad, memSize);

endinterface

// File: design/memWriteback.sv
`timescale 1ns/100ps

module memWriteback (
   input  logic             clk,
   input  cpuPkg::emStage_t em,
   input  cpuPkg::word_t    dataRdata,
   memReqIf.wb              mem,
   output logic             regWrite,
   output cpuPkg::regIdx_t  writeAddr,
   output cpuPkg::word_t    writeData
);

   logic [1:0]       loadLow;
   cpuPkg::memSize_t loadSize;
   logic             loadFresh;
   cpuPkg::word_t    heldData;
   cpuPkg::word_t    rawData;
   logic [15:0]      half;
   logic [7:0]       byteVal;
   cpuPkg::word_t    loadData;

   // Load info captured when the request issues
   // isLoad is low during reset and stall
   always_ff @(posedge clk) begin
      loadFresh <= mem.isLoad;
      if (mem.isLoad) begin
         loadLow  <= mem.addr[1:0];
         loadSize <= mem.memSize;
      end
      // Keep read data while M is stalled
      if (loadFresh) begin
         heldData <= dataRdata;
      end
   end

   assign rawData = loadFresh ? dataRdata : heldData;

   // Lane extraction and extension
   assign half    = loadLow[1] ? rawData[31:16] : rawData[15:0];
   assign byteVal = rawData[8*loadLow +: 8];

   always_comb begin
      case (loadSize)
         cpuPkg::MEM_BYTE:
            loadData = {{24{em.loadSigned & byteVal[7]}}, byteVal};
         cpuPkg::MEM_HALF:
            loadData = {{16{em.loadSigned & half[15]}}, half};
         default:
            loadData = rawData;
      endcase
   end

   // Link value, load data or ALU result
   always_comb begin
      if (em.link) begin
         writeData = em.pc + cpuPkg::linkOffset;
      end else if (em.memToReg) begin
         writeData = loadData;
      end else begin
         writeData = em.aluResult;
      end
   end

   // JAL arrives with dest zero
   assign writeAddr = (em.link && (em.dest == '0)) ? cpuPkg::linkReg : em.dest;
   assign regWrite  = em.regWrite;

endmodule

// File: design/pcCounter.sv
`timescale 1ns/100ps

module pcCounter (
   input  logic          clk,
   input  logic          reset,
   input  logic          stall,
   input  logic          takeBranch,
   input  cpuPkg::word_t branchTarget,
   output cpuPkg::word_t pc
);

   cpuPkg::word_t nextPc;

   // Redirect from E, else sequential
   // Delay slot is already in F when the redirect lands
   always_comb begin
      if (takeBranch) begin
         nextPc = branchTarget;
      end else begin
         nextPc = pc + 32'd4;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         pc <= cpuPkg::resetVector;
      end else if (!stall) begin
         pc <= nextPc;
      end
      // Hold while stalled
   end

endmodule

// File: design/regFile.sv
`timescale 1ns/100ps

module regFile (
   input  logic            clk,
   input  cpuPkg::regIdx_t raddrA,
   input  cpuPkg::regIdx_t raddrB,
   output cpuPkg::word_t   rdataA,
   output cpuPkg::word_t   rdataB,
   input  logic            writeEn,
   input  cpuPkg::regIdx_t waddr,
   input  cpuPkg::word_t   wdata
);

   cpuPkg::word_t regs [32];

   // Write on the edge, r0 never written
   always_ff @(posedge clk) begin
      if (writeEn && (waddr != '0)) begin
         regs[waddr] <= wdata;
      end
   end

   // Async reads, r0 forced to zero
   assign rdataA = (raddrA == '0) ? '0 : regs[raddrA];
   assign rdataB = (raddrB == '0) ? '0 : regs[raddrB];

endmodule

// File: design/stageReg.sv
`timescale 1ns/100ps

module stageReg #(
   parameter type payload_t = logic
) (
   input  logic     clk,
   input  logic     reset,
   input  logic     stall,
   input  payload_t d,
   output payload_t q
);

   // Cleared payload decodes as a no-op
   always_ff @(posedge clk) begin
      if (reset) begin
         q <= '0;
      end else if (!stall) begin
         q <= d;
      end
   end

endmodule

// File: src.f
design/cpuPkg.sv
design/memReqIf.sv
design/pcCounter.sv
design/regFile.sv
design/decodeUnit.sv
design/stageReg.sv
design/executeUnit.sv
design/memWriteback.sv
design/cpuTop.sv
tb/cpuTop_assert.sv
tb/cpuTb.sv

// File: tb/cpuTb.sv
`timescale 1ns/100ps

module cpuTb;

   localparam int clkPeriod = 20;
   // Straight-line words checked before the first branch
   localparam int seqWords  = 24;

   logic            clk;
   logic            reset;
   logic            stall;
   cpuPkg::word_t   instrWord;
   cpuPkg::word_t   dataRdata;
   cpuPkg::word_t   pc;
   cpuPkg::word_t   dataAddr;
   cpuPkg::word_t   dataWdata;
   cpuPkg::byteEn_t dataWe;

   // 1 KB program window at the reset vector, 1 KB data window at 0
   cpuPkg::word_t   imem [256];
   cpuPkg::word_t   dmem [256];
   // Expected stores in program order
   cpuPkg::word_t   expAddr [$];
   cpuPkg::word_t   expData [$];
   cpuPkg::byteEn_t expBe [$];

   integer seed        = 32'hf18584da;
   int     instrCount  = 0;
   int     valueErrors = 0;
   int     storeErrors = 0;
   int     otherErrors = 0;
   logic   loadDone    = 1'b0;

   cpuTop dut_i (
      .clk       (clk),
      .reset     (reset),
      .stall     (stall),
      .instrWord (instrWord),
      .dataRdata (dataRdata),
      .pc        (pc),
      .dataAddr  (dataAddr),
      .dataWdata (dataWdata),
      .dataWe    (dataWe)
   );

   initial begin
      clk = 1'b0;
      forever begin
         #(clkPeriod / 2) clk = ~clk;
      end
   end

   // Combinational instruction fetch, nop outside the window
   assign instrWord = ((pc >> 10) == (cpuPkg::resetVector >> 10)) ? imem[pc[9:2]] : '0;

   // Synchronous read, lane-wise write
   always @(posedge clk) begin
      for (int i = 0; i < 4; i++) begin
         if (dataWe[i]) begin
            dmem[dataAddr[9:2]][8*i +: 8] <= dataWdata[8*i +: 8];
         end
      end
      dataRdata <= dmem[dataAddr[9:2]];
   end

   // Roughly one stalled cycle in four
   always @(posedge clk) begin
      if (reset) begin
         stall <= 1'b0;
      end else begin
         stall <= (($random(seed) & 32'd3) == 32'd0);
      end
   end

   function automatic cpuPkg::word_t laneMask(input cpuPkg::byteEn_t be);
      cpuPkg::word_t mask;
      for (int i = 0; i < 4; i++) begin
         mask[8*i +: 8] = {8{be[i]}};
      end
      return mask;
   endfunction

   task automatic checkAddr(input cpuPkg::word_t got, input cpuPkg::word_t exp);
      if (got !== exp) begin
         $display("** Error at %0d ns: store address 0x%08h, expected 0x%08h", $time, got, exp);
         valueErrors++;
      end
   endtask

   // Only the enabled lanes carry data
   task automatic checkData(input cpuPkg::word_t got, input cpuPkg::byteEn_t gotBe,
                            input cpuPkg::word_t exp, input cpuPkg::byteEn_t expBe);
      cpuPkg::word_t mask;
      mask = laneMask(expBe);
      if ((gotBe !== expBe) || ((got & mask) !== (exp & mask))) begin
         $display("** Error at %0d ns: store data 0x%08h en %b, expected 0x%08h en %b",
                  $time, got & mask, gotBe, exp, expBe);
         valueErrors++;
      end
   endtask

   task automatic checkPc(input cpuPkg::word_t got, input cpuPkg::word_t exp);
      if (got !== exp) begin
         $display("** Error at %0d ns: pc 0x%08h, expected 0x%08h", $time, got, exp);
         valueErrors++;
      end
   endtask

   task automatic loadProgram();
      int              fd;
      int              c;
      int              n;
      cpuPkg::word_t   a;
      cpuPkg::word_t   w;
      cpuPkg::byteEn_t be;
      for (int i = 0; i < 256; i++) begin
         imem[i] = '0;
         dmem[i] = '0;
      end
      fd = $fopen("tb/program_input.txt", "r");
      if (fd == 0) begin
         $display("Cannot open tb/program_input.txt, no program was loaded");
         otherErrors++;
         return;
      end
      c = $fgetc(fd);
      while (c != -1) begin
         if (c[7:0] == "#") begin
            // Comment runs to end of line
            while ((c != -1) && (c[7:0] != "\n")) begin
               c = $fgetc(fd);
            end
         end else if (c[7:0] == "I") begin
            n = $fscanf(fd, "%h %h", a, w);
            if (n != 2) begin
               $display("Malformed instruction line in tb/program_input.txt");
               otherErrors++;
            end
            imem[a[9:2]] = w;
            instrCount++;
         end else if (c[7:0] == "D") begin
            n = $fscanf(fd, "%h %h", a, w);
            if (n != 2) begin
               $display("Malformed data line in tb/program_input.txt");
               otherErrors++;
            end
            dmem[a[9:2]] = w;
         end else if (c[7:0] == "E") begin
            n = $fscanf(fd, "%h %h %h", a, w, be);
            if (n != 3) begin
               $display("Malformed expected store line in tb/program_input.txt");
               otherErrors++;
            end
            expAddr.push_back(a);
            expData.push_back(w);
            expBe.push_back(be);
         end
         c = $fgetc(fd);
      end
      $fclose(fd);
   endtask

   task automatic reportAndFinish();
      int assertFails;
      assertFails = dut_i.assert_i.failCount;
      $display("Errors: value %0d, store %0d, other %0d, assertion %0d",
               valueErrors, storeErrors, otherErrors, assertFails);
      if ((valueErrors + storeErrors + otherErrors + assertFails) == 0) begin
         $display("test passed");
      end else begin
         $display("test failed");
      end
      $finish;
   endtask

   // Store monitor, mid-cycle when DUT outputs are settled
   always @(negedge clk) begin
      if (!reset && (dataWe != '0)) begin
         if (expAddr.size() == 0) begin
            $display("Unexpected store to 0x%08h at %0d ns, no more stores were expected",
                     dataAddr, $time);
            storeErrors++;
         end else begin
            checkAddr(dataAddr, expAddr.pop_front());
            checkData(dataWdata, dataWe, expData.pop_front(), expBe.pop_front());
         end
      end
   end

   // Sequential fetch from the reset vector
   initial begin : pcSequence
      cpuPkg::word_t expPc;
      int            steps;
      expPc = cpuPkg::resetVector;
      steps = 0;
      @(negedge clk);
      while (reset) begin
         @(negedge clk);
      end
      while (steps < seqWords) begin
         checkPc(pc, expPc);
         // Stall seen here applies at the next edge
         if (!stall) begin
            expPc = expPc + 32'd4;
            steps++;
         end
         @(negedge clk);
      end
   end

   // Bound scales with program length, factor 4 for stalls
   initial begin : watchdog
      wait (loadDone);
      #((instrCount + 64) * 4 * clkPeriod);
      $display("Timeout: the program did not finish, %0d expected stores never came",
               expAddr.size());
      otherErrors++;
      storeErrors += expAddr.size();
      reportAndFinish();
   end

   initial begin
      reset     = 1'b1;
      stall     = 1'b0;
      dataRdata = '0;
      loadProgram();
      loadDone = 1'b1;
      repeat (3) @(posedge clk);
      reset <= 1'b0;
      while (expAddr.size() != 0) begin
         @(posedge clk);
      end
      // Let any spurious store after the last one show up
      repeat (20) @(posedge clk);
      reportAndFinish();
   end

endmodule

// File: tb/cpuTop_assert.sv
`timescale 1ns/100ps

module cpuTopAssert (
   input logic            clk,
   input logic            reset,
   input logic            stall,
   input cpuPkg::word_t   pc,
   input cpuPkg::byteEn_t dataWe
);

   // Read back by the testbench at the end of the run
   int   failCount = 0;
   logic primed = 1'b0;

   // Pipeline registers are unknown until the first reset edge
   always @(posedge clk) begin
      primed <= 1'b1;
   end

   // No store strobe during reset or stall
   storeQuiet: assert property (@(posedge clk) disable iff (!primed)
      (reset || stall) |-> (dataWe == '0))
      else begin
         $error("dataWe active during reset or stall");
         failCount++;
      end

   // Stall freezes the program counter
   pcHold: assert property (@(posedge clk) disable iff (!primed)
      (stall && !reset) |=> (pc == $past(pc)))
      else begin
         $error("pc moved across a stalled clock");
         failCount++;
      end

   pcAligned: assert property (@(posedge clk) disable iff (!primed)
      pc[1:0] == 2'b00)
      else begin
         $error("pc not word aligned");
         failCount++;
      end

endmodule

bind cpuTop cpuTopAssert assert_i (
   .clk    (clk),
   .reset  (reset),
   .stall  (stall),
   .pc     (pc),
   .dataWe (dataWe)
);

// File: tb/program_input.txt
# I addr word: instruction | D addr word: initial data word
# E addr data be: expected store in program order, data in its enabled lanes
I 40000000 34011234  # ori   r1, r0, 0x1234
I 40000004 3C02ABCD  # lui   r2, 0xabcd
I 40000008 00221821  # addu  r3, r1, r2
I 4000000C AC030100  # sw    r3, 0x100(r0)
I 40000010 2404FFFB  # addiu r4, r0, -5
I 40000014 0081282A  # slt   r5, r4, r1
I 40000018 00013100  # sll   r6, r1, 4
I 4000001C 00C53823  # subu  r7, r6, r5
I 40000020 38E8FFFF  # xori  r8, r7, 0xffff
I 40000024 AC080104  # sw    r8, 0x104(r0)
I 40000028 30898F0F  # andi  r9, r4, 0x8f0f
I 4000002C AC050108  # sw    r5, 0x108(r0)
I 40000030 A009010D  # sb    r9, 0x10d(r0)
I 40000034 A4010112  # sh    r1, 0x112(r0)
I 40000038 800A0203  # lb    r10, 0x203(r0)
I 4000003C 900B0202  # lbu   r11, 0x202(r0)
I 40000040 840C0202  # lh    r12, 0x202(r0)
I 40000044 940D0200  # lhu   r13, 0x200(r0)
I 40000048 8C0E0200  # lw    r14, 0x200(r0)
I 4000004C AC0A0114  # sw    r10, 0x114(r0)
I 40000050 AC0E0118  # sw    r14, 0x118(r0)
I 40000054 AC0B011C  # sw    r11, 0x11c(r0)
I 40000058 AC0C0120  # sw    r12, 0x120(r0)
I 4000005C AC0D0124  # sw    r13, 0x124(r0)
I 40000060 14210003  # bne   r1, r1, +3 (not taken)
I 40000064 240F0055  # addiu r15, r0, 0x55
I 40000068 11EF0002  # beq   r15, r15, +2 (taken)
I 4000006C AC0F0128  # sw    r15, 0x128(r0)
I 40000070 AC00012C  # sw    r0, 0x12c(r0) skipped
I 40000074 0C000024  # jal   0x40000090
I 40000078 34100077  # ori   r16, r0, 0x77
I 4000007C 3C124000  # lui   r18, 0x4000
I 40000080 365200A0  # ori   r18, r18, 0xa0
I 40000084 02409809  # jalr  r19, r18
I 40000088 24140066  # addiu r20, r0, 0x66
I 4000008C AC00012C  # sw    r0, 0x12c(r0) skipped
I 40000090 AC1F0130  # sw    r31, 0x130(r0)
I 40000094 03E00008  # jr    r31
I 40000098 AC100134  # sw    r16, 0x134(r0)
I 400000A0 AC130138  # sw    r19, 0x138(r0)
I 400000A4 AC14013C  # sw    r20, 0x13c(r0)
I 400000A8 0800002A  # j     0x400000a8
I 400000AC 00000000  # nop
D 00000200 80F17F23
E 00000100 ABCD1234 F
E 00000104 0001DCC0 F
E 00000108 00000001 F
E 0000010D 00000B00 2
E 00000112 12340000 C
E 00000114 FFFFFF80 F
E 00000118 80F17F23 F
E 0000011C 000000F1 F
E 00000120 FFFF80F1 F
E 00000124 00007F23 F
E 00000128 00000055 F
E 00000130 4000007C F
E 00000134 00000077 F
E 00000138 4000008C F
E 0000013C 00000066 F
